/* verilog/tile_pkg.sv */
`default_nettype none

package tile_pkg;

    // geometry
    localparam int num_layers = 2;
    localparam int screen_w   = 256;   // visible pixels per line
    localparam int map_dim    = 32;    // tiles per map side, single page

    // graphics memory
    localparam int mem_aw      = 13;   // 8k words
    localparam int mem_dw      = 32;
    localparam int credits     = 2;    // outstanding reads per layer
    localparam int mem_latency = 2;    // request to response, cycles

    // memory map in words
    localparam logic [mem_aw-1:0] map_base0 = 13'd0;
    localparam logic [mem_aw-1:0] map_base1 = 13'd1024;
    localparam logic [mem_aw-1:0] tile_base = 13'd4096;  // 8 words per tile, one per row

    // map entry, low half of the map word
    typedef struct packed {
        logic       prio;
        logic [2:0] palette;
        logic [2:0] reserved;
        logic [8:0] code;
    } map_word_t;

    typedef struct packed {
        logic              valid;
        logic [mem_aw-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic              tag;    // layer index
        logic [mem_dw-1:0] data;
    } mem_rsp_t;

    // color 0 is transparent
    typedef struct packed {
        logic       prio;
        logic [2:0] palette;
        logic [3:0] color;
    } layer_pixel_t;

    typedef struct packed {
        logic         layer;  // 1 when the foreground won
        layer_pixel_t pix;
    } mix_pixel_t;

endpackage

`default_nettype wire

/* verilog/gfx_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module gfx_memory (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_en,
    input  logic [tile_pkg::mem_aw-1:0]      load_addr,
    input  logic [tile_pkg::mem_dw-1:0]      load_data,
    input  tile_pkg::mem_req_t               req,
    input  logic                             req_tag,
    output tile_pkg::mem_rsp_t               rsp
);

    logic [tile_pkg::mem_dw-1:0] mem [2**tile_pkg::mem_aw];

    // stage 1 holds the address, stage 2 the data
    logic                        s1_valid;
    logic                        s1_tag;
    logic [tile_pkg::mem_aw-1:0] s1_addr;
    logic                        rsp_valid;
    logic                        rsp_tag;
    logic [tile_pkg::mem_dw-1:0] rsp_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= req.valid;
            rsp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_data;  // host fill
        s1_addr  <= req.addr;
        s1_tag   <= req_tag;
        rsp_data <= mem[s1_addr];
        rsp_tag  <= s1_tag;              // tag rides with the data
    end

    assign rsp = '{valid: rsp_valid, tag: rsp_tag, data: rsp_data};

    // host only loads while nothing renders
    a_no_load_during_read: assert property (@(posedge clk) disable iff (rst)
        !(load_en && req.valid))
        else $error("host write collides with a layer read");

endmodule

`default_nettype wire

/* verilog/gfx_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module gfx_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  tile_pkg::mem_req_t                req0,
    input  tile_pkg::mem_req_t                req1,
    input  tile_pkg::mem_rsp_t                mem_rsp,
    output logic [tile_pkg::num_layers-1:0]   grant,
    output tile_pkg::mem_req_t                mem_req,
    output logic                              req_tag,
    output tile_pkg::mem_rsp_t                rsp0,
    output tile_pkg::mem_rsp_t                rsp1
);

    logic last;  // layer that won the previous grant

    always_comb begin
        if (req0.valid && req1.valid)
            grant = last ? 2'b01 : 2'b10;  // alternate under contention
        else
            grant = {req1.valid, req0.valid};
        req_tag = grant[1];
        mem_req = grant[1] ? req1 : req0;
        mem_req.valid = |grant;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            last <= 1'b1;  // layer 0 first
        else if (|grant)
            last <= grant[1];
    end

    // response steering by tag
    always_comb begin
        rsp0       = mem_rsp;
        rsp0.valid = mem_rsp.valid && !mem_rsp.tag;
        rsp1       = mem_rsp;
        rsp1.valid = mem_rsp.valid && mem_rsp.tag;
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant))
        else $error("more than one grant");

endmodule

`default_nettype wire

/* verilog/scroll_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module scroll_layer #(
    parameter bit layer_id = 1'b0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   line_start,
    input  logic [7:0]             vrender,
    input  logic [7:0]             hscr,
    input  logic [7:0]             vscr,
    input  logic                   grant,
    input  tile_pkg::mem_rsp_t     rsp,
    output tile_pkg::mem_req_t     req,
    output logic                   wr_en,
    output logic [7:0]             wr_addr,
    output tile_pkg::layer_pixel_t wr_data
);

    localparam logic [tile_pkg::mem_aw-1:0] map_base =
        layer_id ? tile_pkg::map_base1 : tile_pkg::map_base0;

    logic        drawing;
    logic [7:0]  vpos;       // map line for this render
    logic [7:0]  hscr_q;
    logic [5:0]  map_col;    // next column for a map read, 0..33
    logic [5:0]  pat_col;    // next column for a pattern read
    logic [1:0]  cr;         // free credits

    // request register, held until granted
    logic                        req_valid;
    logic [tile_pkg::mem_aw-1:0] req_addr;
    logic                        req_map;   // 1 map read, 0 pattern read

    // response buffer, kinds pushed at grant, data at response
    logic [1:0]  kind_q;
    logic [31:0] dat_q [2];
    logic        k_wp;
    logic        d_wp;
    logic        rd_p;
    logic [1:0]  d_cnt;

    tile_pkg::map_word_t ent;  // map entry waiting for its pattern read
    logic        ent_valid;
    logic        pat_pend;     // pattern read in flight
    logic [3:0]  pend_attr;    // prio and palette of that read

    // pixel shifter
    logic [31:0] shreg;
    logic        shift_on;
    logic [2:0]  nib;
    logic [5:0]  cur_col;
    logic [3:0]  cur_attr;

    logic        taken;
    logic        head_map;
    logic        pop;
    logic        load_pat;
    logic        pick_pat;
    logic        pick_map;
    logic [4:0]  map_x;
    logic [9:0]  pos;

    assign taken    = req_valid && grant;
    assign head_map = kind_q[rd_p];
    assign pop      = (d_cnt != 2'd0) &&
                      (head_map ? !ent_valid : (!shift_on || nib == 3'd7));
    assign load_pat = pop && !head_map;

    // pattern first, map reads at most two tiles ahead
    assign pick_pat = drawing && !req_valid && cr != 2'd0 && ent_valid && !pat_pend;
    assign pick_map = drawing && !req_valid && cr != 2'd0 && !pick_pat &&
                      map_col <= 6'(tile_pkg::map_dim) && map_col < pat_col + 6'd2;

    assign map_x = 5'(map_col[4:0] + hscr_q[7:3]);  // wraps at 32 tiles

    assign req = '{valid: req_valid, addr: req_addr};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drawing   <= 1'b0;
            req_valid <= 1'b0;
            map_col   <= '0;
            pat_col   <= '0;
            cr        <= 2'(tile_pkg::credits);
            k_wp      <= 1'b0;
            d_wp      <= 1'b0;
            rd_p      <= 1'b0;
            d_cnt     <= '0;
            ent_valid <= 1'b0;
            pat_pend  <= 1'b0;
            shift_on  <= 1'b0;
            nib       <= '0;
        end else begin
            if (taken) begin
                req_valid <= 1'b0;  // one idle cycle before the next pick
                k_wp      <= ~k_wp;
            end else if (pick_pat || pick_map) begin
                req_valid <= 1'b1;
            end
            if (pick_pat) begin
                pat_col   <= pat_col + 6'd1;
                pat_pend  <= 1'b1;
                ent_valid <= 1'b0;
            end
            if (pick_map)
                map_col <= map_col + 6'd1;
            cr    <= cr - {1'b0, taken} + {1'b0, pop};  // reserve on grant
            d_cnt <= d_cnt + {1'b0, rsp.valid} - {1'b0, pop};
            if (rsp.valid)
                d_wp <= ~d_wp;
            if (pop)
                rd_p <= ~rd_p;
            if (pop && head_map)
                ent_valid <= 1'b1;
            if (load_pat) begin
                pat_pend <= 1'b0;
                shift_on <= 1'b1;
                nib      <= '0;
            end else if (shift_on) begin
                nib <= nib + 3'd1;
                if (nib == 3'd7)
                    shift_on <= 1'b0;
            end
            // last pixel of column 32 ends the line
            if (shift_on && nib == 3'd7 && cur_col == 6'(tile_pkg::map_dim))
                drawing <= 1'b0;
            if (line_start) begin
                drawing <= 1'b1;
                map_col <= '0;
                pat_col <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start) begin
            vpos   <= vrender + vscr;  // wraps at 256
            hscr_q <= hscr;
        end
        if (pick_pat) begin
            req_addr  <= tile_pkg::tile_base + {1'b0, ent.code, vpos[2:0]};
            req_map   <= 1'b0;
            pend_attr <= {ent.prio, ent.palette};
        end else if (pick_map) begin
            req_addr <= map_base + {3'b0, vpos[7:3], map_x};
            req_map  <= 1'b1;
        end
        if (taken)
            kind_q[k_wp] <= req_map;
        if (rsp.valid)
            dat_q[d_wp] <= rsp.data;
        if (pop && head_map)
            ent <= tile_pkg::map_word_t'(dat_q[rd_p][15:0]);
        if (load_pat) begin
            shreg    <= dat_q[rd_p];
            cur_col  <= pat_col - 6'd1;  // only one pattern read at a time
            cur_attr <= pend_attr;
        end else if (shift_on) begin
            shreg <= shreg << 4;  // leftmost pixel in the top nibble
        end
    end

    // screen x, fine scroll pulls pixels left
    assign pos     = {1'b0, cur_col, nib} - {7'd0, hscr_q[2:0]};
    assign wr_en   = shift_on && pos < 10'(tile_pkg::screen_w);
    assign wr_addr = pos[7:0];
    assign wr_data = '{prio: cur_attr[3], palette: cur_attr[2:0], color: shreg[31:28]};

    a_credit_range: assert property (@(posedge clk) disable iff (rst)
        cr <= 2'(tile_pkg::credits))
        else $error("credit count out of range");

    // line period too short for the fetch
    a_line_done: assert property (@(posedge clk) disable iff (rst)
        line_start |-> !drawing)
        else $error("line_start while still drawing");

endmodule

`default_nettype wire

/* verilog/line_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   line_start,
    input  logic                   wr_en,
    input  logic [7:0]             wr_addr,
    input  tile_pkg::layer_pixel_t wr_data,
    input  logic [7:0]             rd_addr,
    output tile_pkg::layer_pixel_t rd_data
);

    tile_pkg::layer_pixel_t mem [2][tile_pkg::screen_w];

    // written flags, an unwritten entry reads as transparent
    logic [tile_pkg::screen_w-1:0] vld [2];
    logic sel;  // write bank, reads use the other

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel    <= 1'b0;
            vld[0] <= '0;
            vld[1] <= '0;
        end else begin
            if (line_start) begin
                sel      <= ~sel;
                vld[~sel] <= '0;  // displayed bank comes back empty
            end
            if (wr_en)
                vld[sel][wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[sel][wr_addr] <= wr_data;
        rd_data <= vld[~sel][rd_addr] ? mem[~sel][rd_addr] : '0;  // one cycle read
    end

endmodule

`default_nettype wire

/* verilog/layer_mixer.sv */
`timescale 1ns/1ns
`default_nettype none

module layer_mixer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  tile_pkg::layer_pixel_t bg,   // layer 0
    input  tile_pkg::layer_pixel_t fg,   // layer 1
    output logic                   pxl_valid,
    output tile_pkg::mix_pixel_t   pxl
);

    logic fg_win;

    // opaque fg wins unless a prio bg sits under a non-prio fg
    assign fg_win = (fg.color != 4'd0) &&
                    !(bg.prio && !fg.prio && bg.color != 4'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pxl_valid <= 1'b0;
        else
            pxl_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (fg_win)
            pxl <= '{layer: 1'b1, pix: fg};
        else
            pxl <= '{layer: 1'b0, pix: bg};  // also the all-transparent case
    end

endmodule

`default_nettype wire

/* verilog/tilemap_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tilemap_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_en,
    input  logic [tile_pkg::mem_aw-1:0] load_addr,
    input  logic [tile_pkg::mem_dw-1:0] load_data,
    input  logic                        line_start,
    input  logic [7:0]                  vrender,
    input  logic [7:0]                  hscr0,
    input  logic [7:0]                  vscr0,
    input  logic [7:0]                  hscr1,
    input  logic [7:0]                  vscr1,
    input  logic                        hdump_valid,
    input  logic [7:0]                  hdump,
    output logic                        pxl_valid,
    output tile_pkg::mix_pixel_t        pxl
);

    tile_pkg::mem_req_t     req0, req1, mem_req;
    tile_pkg::mem_rsp_t     rsp0, rsp1, mem_rsp;
    logic [tile_pkg::num_layers-1:0] grant;
    logic                   req_tag;
    logic                   wr_en0, wr_en1;
    logic [7:0]             wr_addr0, wr_addr1;
    tile_pkg::layer_pixel_t wr_data0, wr_data1;
    tile_pkg::layer_pixel_t bg, fg;
    logic                   hdump_valid_q;  // aligned with line buffer data

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            hdump_valid_q <= 1'b0;
        else
            hdump_valid_q <= hdump_valid;
    end

    gfx_memory gfx_memory_inst (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .req       (mem_req),
        .req_tag   (req_tag),
        .rsp       (mem_rsp)
    );

    gfx_arbiter gfx_arbiter_inst (
        .clk     (clk),
        .rst     (rst),
        .req0    (req0),
        .req1    (req1),
        .mem_rsp (mem_rsp),
        .grant   (grant),
        .mem_req (mem_req),
        .req_tag (req_tag),
        .rsp0    (rsp0),
        .rsp1    (rsp1)
    );

    // background
    scroll_layer #(.layer_id(1'b0)) scroll_layer0_inst (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .hscr       (hscr0),
        .vscr       (vscr0),
        .grant      (grant[0]),
        .rsp        (rsp0),
        .req        (req0),
        .wr_en      (wr_en0),
        .wr_addr    (wr_addr0),
        .wr_data    (wr_data0)
    );

    // foreground
    scroll_layer #(.layer_id(1'b1)) scroll_layer1_inst (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .hscr       (hscr1),
        .vscr       (vscr1),
        .grant      (grant[1]),
        .rsp        (rsp1),
        .req        (req1),
        .wr_en      (wr_en1),
        .wr_addr    (wr_addr1),
        .wr_data    (wr_data1)
    );

    line_buffer line_buffer0_inst (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .wr_en      (wr_en0),
        .wr_addr    (wr_addr0),
        .wr_data    (wr_data0),
        .rd_addr    (hdump),
        .rd_data    (bg)
    );

    line_buffer line_buffer1_inst (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .wr_en      (wr_en1),
        .wr_addr    (wr_addr1),
        .wr_data    (wr_data1),
        .rd_addr    (hdump),
        .rd_data    (fg)
    );

    layer_mixer layer_mixer_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (hdump_valid_q),
        .bg        (bg),
        .fg        (fg),
        .pxl_valid (pxl_valid),
        .pxl       (pxl)
    );

endmodule

`default_nettype wire

/* verification/tilemap_ref.svh */
`ifndef TILEMAP_REF_SVH
`define TILEMAP_REF_SVH

// image of the graphics memory, every host load lands here too
logic [tile_pkg::mem_dw-1:0] mirror [2**tile_pkg::mem_aw];
logic [31:0] lcg_state = 32'h6252eacb;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// low lcg bits repeat quickly, so take the upper halves of two steps
function automatic logic [31:0] random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
endfunction

// pixel one layer puts at screen x for a line latched with these values
function automatic tile_pkg::layer_pixel_t layer_pixel_at(input bit layer,
    input logic [7:0] x, input logic [7:0] vrender, input logic [7:0] hscr,
    input logic [7:0] vscr);
    logic [7:0] vpos;
    int sx;
    int col;
    int map_addr;
    int pat_addr;
    tile_pkg::map_word_t ent;
    logic [31:0] row;
    tile_pkg::layer_pixel_t p;
    vpos = vrender + vscr;                 // wraps at 256
    sx = int'(x) + int'(hscr[2:0]);        // world x inside the 33 fetched tiles
    col = (sx / 8 + int'(hscr[7:3])) % tile_pkg::map_dim;
    map_addr = int'(layer ? tile_pkg::map_base1 : tile_pkg::map_base0)
        + int'(vpos[7:3]) * tile_pkg::map_dim + col;
    ent = tile_pkg::map_word_t'(mirror[map_addr][15:0]);
    pat_addr = int'(tile_pkg::tile_base) + int'(ent.code) * 8 + int'(vpos[2:0]);
    row = mirror[pat_addr];
    p.prio = ent.prio;
    p.palette = ent.palette;
    p.color = 4'(row >> (28 - 4 * (sx % 8)));  // leftmost pixel in the top nibble
    return p;
endfunction

// foreground over background unless a prio bg sits under a plain fg
function automatic tile_pkg::mix_pixel_t mixed_pixel(input tile_pkg::layer_pixel_t bg,
    input tile_pkg::layer_pixel_t fg);
    tile_pkg::mix_pixel_t m;
    logic bg_holds;
    bg_holds = bg.prio && !fg.prio && bg.color != 4'd0;
    if (fg.color != 4'd0 && !bg_holds) begin
        m.layer = 1'b1;
        m.pix = fg;
    end else begin
        m.layer = 1'b0;  // includes both transparent
        m.pix = bg;
    end
    return m;
endfunction

`endif

/* verification/tilemap_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module tilemap_tb;

    localparam int clk_period  = 100;
    localparam int line_period = 400;     // cycles per display line
    localparam int hdump_wait  = 40;      // line_start to first hdump
    localparam int n_lines     = 24;
    localparam int n_loads     = 19464;   // host words written over the whole run
    localparam int watchdog_cycles = n_lines * line_period + n_loads + 1000;

    logic                        clk;
    logic                        rst;
    logic                        load_en;
    logic [tile_pkg::mem_aw-1:0] load_addr;
    logic [tile_pkg::mem_dw-1:0] load_data;
    logic                        line_start;
    logic [7:0]                  vrender;
    logic [7:0]                  hscr0;
    logic [7:0]                  vscr0;
    logic [7:0]                  hscr1;
    logic [7:0]                  vscr1;
    logic                        hdump_valid;
    logic [7:0]                  hdump;
    logic                        pxl_valid;
    tile_pkg::mix_pixel_t        pxl;

    int checks = 0;
    int errors = 0;
    tile_pkg::mix_pixel_t exp_q [$];        // expected pixels in display order
    tile_pkg::mix_pixel_t exp_pix;
    tile_pkg::mix_pixel_t cur_line [256];   // line on screen this period
    tile_pkg::mix_pixel_t next_line [256];  // line the layers render now

    `include "tilemap_ref.svh"

    tilemap_top tilemap_top_inst (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .line_start  (line_start),
        .vrender     (vrender),
        .hscr0       (hscr0),
        .vscr0       (vscr0),
        .hscr1       (hscr1),
        .vscr1       (vscr1),
        .hdump_valid (hdump_valid),
        .hdump       (hdump),
        .pxl_valid   (pxl_valid),
        .pxl         (pxl)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_word(input logic [12:0] addr, input logic [31:0] data);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        mirror[addr] = data;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic fill_random(input int first, input int count);
        int a;
        for (a = first; a < first + count; a++)
            load_word(13'(a), random_word());
    endtask

    // one line period, starts and ends on a falling edge
    task automatic run_line(input logic [7:0] vr, input logic [7:0] h0,
        input logic [7:0] v0, input logic [7:0] h1, input logic [7:0] v1);
        int x;
        cur_line = next_line;  // rendered last period, shown now
        for (x = 0; x < 256; x++)
            next_line[x] = mixed_pixel(layer_pixel_at(1'b0, 8'(x), vr, h0, v0),
                                       layer_pixel_at(1'b1, 8'(x), vr, h1, v1));
        line_start = 1'b1;
        vrender    = vr;
        hscr0      = h0;
        vscr0      = v0;
        hscr1      = h1;
        vscr1      = v1;
        @(negedge clk);
        line_start = 1'b0;
        repeat (hdump_wait - 1) @(negedge clk);
        for (x = 0; x < 256; x++) begin
            hdump_valid = 1'b1;
            hdump       = 8'(x);
            exp_q.push_back(cur_line[x]);
            @(negedge clk);
        end
        hdump_valid = 1'b0;
        repeat (line_period - hdump_wait - 256) @(negedge clk);
    endtask

    // outputs settle after the rising edge, sample on the falling one
    always @(negedge clk) begin
        if (pxl_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("pixel came out at %0t with nothing expected", $time);
            end else begin
                exp_pix = exp_q.pop_front();
                compare_value("pxl", pxl, exp_pix);
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("run timed out after %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int i;
        logic [31:0] r0;
        logic [31:0] r1;
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        line_start = 1'b0;
        vrender = '0;
        hscr0 = '0;
        vscr0 = '0;
        hscr1 = '0;
        vscr1 = '0;
        hdump_valid = 1'b0;
        hdump = '0;
        for (i = 0; i < 256; i++) begin
            cur_line[i]  = '0;
            next_line[i] = '0;  // nothing rendered before the first line
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        compare_value("pxl_valid", pxl_valid, 1'b0);

        // random image, then a transparent foreground map on tile 0
        fill_random(0, 8192);
        for (i = 1024; i < 2048; i++)
            load_word(13'(i), 32'h0);
        for (i = 4096; i < 4104; i++)
            load_word(13'(i), 32'h0);

        run_line(8'd0, 8'd0, 8'd0, 8'd0, 8'd0);  // shows the empty line
        run_line(8'd8, 8'd0, 8'd0, 8'd0, 8'd0);
        run_line(8'd133, 8'd0, 8'd0, 8'd0, 8'd0);

        // horizontal scroll, coarse and fine
        run_line(8'd20, 8'd13, 8'd0, 8'd0, 8'd0);
        run_line(8'd21, 8'd200, 8'd0, 8'd0, 8'd0);
        run_line(8'd22, 8'd255, 8'd0, 8'd5, 8'd0);

        // vpos past 255
        run_line(8'd200, 8'd3, 8'd100, 8'd0, 8'd77);
        run_line(8'd255, 8'd0, 8'd255, 8'd0, 8'd0);

        // both maps random, prio bits mixed
        fill_random(0, 2048);
        run_line(8'd40, 8'd0, 8'd0, 8'd0, 8'd0);
        run_line(8'd41, 8'd9, 8'd30, 8'd250, 8'd6);
        run_line(8'd90, 8'd77, 8'd180, 8'd3, 8'd201);

        fill_random(0, 8192);
        for (i = 0; i < 12; i++) begin
            r0 = random_word();
            r1 = random_word();
            run_line(r0[7:0], r0[15:8], r0[23:16], r0[31:24], r1[7:0]);
        end
        run_line(8'd0, 8'd0, 8'd0, 8'd0, 8'd0);  // displays the last render

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected pixels never came out", exp_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verification
verilog/tile_pkg.sv
verilog/gfx_memory.sv
verilog/gfx_arbiter.sv
verilog/scroll_layer.sv
verilog/line_buffer.sv
verilog/layer_mixer.sv
verilog/tilemap_top.sv
verification/tilemap_tb.sv

/* Bender.yml */
package:
  name: tilemap

sources:
  - files:
      - verilog/tile_pkg.sv
      - verilog/gfx_memory.sv
      - verilog/gfx_arbiter.sv
      - verilog/scroll_layer.sv
      - verilog/line_buffer.sv
      - verilog/layer_mixer.sv
      - verilog/tilemap_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tilemap_tb.sv
